/* dma_rd_bench.f */
dma_bench_pkg.sv
dma_rd_fsm.sv
dma_perf_timer.sv
dma_rd_checker.sv
dma_rd_bench.sv
tb_clk_gen.sv
dma_rd_bench_tb.sv

/* Bender.yml */
package:
  name: dma_rd_bench

sources:
  - dma_bench_pkg.sv
  - dma_rd_fsm.sv
  - dma_perf_timer.sv
  - dma_rd_checker.sv
  - dma_rd_bench.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - dma_rd_bench_tb.sv

/* dma_rd_bench_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_rd_bench_tb;

	////////////////////////////////////////////////////////////////////////////
	// run sizing and watchdog limit
	////////////////////////////////////////////////////////////////////////////

	// worst idle cycles between two beats
	localparam int idle_max = 2;
	// beats and lead gaps over the three runs
	localparam int run_beats = 8 + 16 + 4;
	localparam int run_gaps = 3 + 4 + 0;
	// start, ready stall, settle and start drop per run
	localparam int run_fixed = 16;
	localparam int cycle_limit =
		2 * (run_beats * (idle_max + 1) + run_gaps + 3 * run_fixed + 20);

	wire          pcie_clk;
	wire          pcie_aresetn;
	logic         rd_start;
	logic [63:0]  rd_addr;
	logic [31:0]  rd_length;
	logic [31:0]  rd_offset;
	logic         cmd_ready;
	logic         rd_data_valid;
	logic [511:0] rd_data;
	wire          cmd_valid;
	wire  [63:0]  cmd_addr;
	wire  [31:0]  cmd_length;
	wire  [31:0]  rd_th_sum;
	wire  [31:0]  rd_lat_sum;
	wire  [31:0]  error_cnt;
	wire  [31:0]  error_index;

	integer       seed;
	int           error_count;
	int           check_cnt;
	int           cycle_cnt;
	// tb side model of the results
	logic [31:0]  exp_err_cnt;
	logic [31:0]  exp_th;
	logic [31:0]  exp_lat;
	logic [31:0]  exp_idx;
	logic [63:0]  bad_mask;
	int           gap_b;
	int           k;

	tb_clk_gen u_clk (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn)
	);

	dma_rd_bench uut (
		.pcie_clk      (pcie_clk),
		.pcie_aresetn  (pcie_aresetn),
		.rd_start      (rd_start),
		.rd_addr       (rd_addr),
		.rd_length     (rd_length),
		.rd_offset     (rd_offset),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_addr      (cmd_addr),
		.cmd_length    (cmd_length),
		.rd_data_valid (rd_data_valid),
		.rd_data       (rd_data),
		.rd_th_sum     (rd_th_sum),
		.rd_lat_sum    (rd_lat_sum),
		.error_cnt     (error_cnt),
		.error_index   (error_index)
	);

	////////////////////////////////////////////////////////////////////////////
	// protocol assertions
	////////////////////////////////////////////////////////////////////////////

	// command holds while the core stalls
	cmd_hold_a: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
		cmd_valid && !cmd_ready |=> cmd_valid)
	else begin
		error_count++;
		$display("ERROR %0t cmd_valid expected 1 got 0", $time);
	end

	// payload is a straight pass of the run inputs
	cmd_addr_a: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
		cmd_valid |-> cmd_addr == rd_addr)
	else begin
		error_count++;
		$display("ERROR %0t cmd_addr expected %0h got %0h", $time, rd_addr, cmd_addr);
	end

	// value compare, sampled on the falling edge
	task automatic check_val(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		check_cnt++;
		assert (act === exp)
		else begin
			error_count++;
			$display("ERROR %0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	// random upper words, counting pattern in the low word
	function automatic logic [511:0] make_beat(input int idx, input logic [31:0] offset,
		input logic bad);
		logic [511:0] beat;
		int           w;
		for (w = 0; w < 16; w++) begin
			beat[w*32 +: 32] = $random(seed);
		end
		beat[31:0] = idx + offset;
		// nonzero flip so the word is always wrong
		if (bad) begin
			beat[31:0] = beat[31:0] ^ ({$random(seed)} | 32'h1);
		end
		return beat;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// one run: start, command stall, memory side answer, result check
	////////////////////////////////////////////////////////////////////////////

	task automatic run_transfer(input logic [63:0] addr, input int n_beats, input int gap,
		input int idle_lim, input int ready_delay, input logic [31:0] offset,
		input logic [63:0] mask);
		int idle;
		int idle_total;
		int first_bad;
		int i;
		idle_total = 0;
		first_bad = -1;
		for (i = 0; i < n_beats; i++) begin
			if (mask[i]) begin
				exp_err_cnt = exp_err_cnt + 1;
				if (first_bad < 0) begin
					first_bad = i;
				end
			end
		end
		rd_addr   = addr;
		rd_length = n_beats << 6;
		rd_offset = offset;
		rd_start  = 1'b1;
		// valid comes two rising edges after the start level
		@(negedge pcie_clk);
		check_val("cmd_valid", 0, cmd_valid);
		@(negedge pcie_clk);
		check_val("cmd_valid", 1, cmd_valid);
		check_val("cmd_addr", addr, cmd_addr);
		check_val("cmd_length", n_beats << 6, cmd_length);
		// start clears the per run results only
		check_val("rd_th_sum", 0, rd_th_sum);
		check_val("rd_lat_sum", 0, rd_lat_sum);
		check_val("error_index", 0, error_index);
		check_val("error_cnt", exp_err_cnt - mask_count(mask, n_beats), error_cnt);
		repeat (ready_delay) begin
			@(negedge pcie_clk);
			check_val("cmd_valid", 1, cmd_valid);
		end
		cmd_ready = 1'b1;
		@(negedge pcie_clk);
		cmd_ready = 1'b0;
		check_val("cmd_valid", 0, cmd_valid);
		// memory latency before the first beat
		repeat (gap) begin
			@(negedge pcie_clk);
		end
		for (i = 0; i < n_beats; i++) begin
			rd_data       = make_beat(i, offset, mask[i]);
			rd_data_valid = 1'b1;
			@(negedge pcie_clk);
			rd_data_valid = 1'b0;
			if (i < n_beats - 1) begin
				idle = {$random(seed)} % (idle_lim + 1);
				idle_total += idle;
				repeat (idle) @(negedge pcie_clk);
			end
		end
		exp_th  = gap + n_beats + idle_total;
		exp_lat = gap + 1;
		exp_idx = (first_bad < 0) ? 0 : first_bad;
		check_val("rd_th_sum", exp_th, rd_th_sum);
		check_val("rd_lat_sum", exp_lat, rd_lat_sum);
		check_val("error_cnt", exp_err_cnt, error_cnt);
		check_val("error_index", exp_idx, error_index);
		// data phase must be over, counters frozen
		@(negedge pcie_clk);
		check_val("rd_th_sum", exp_th, rd_th_sum);
		check_val("cmd_valid", 0, cmd_valid);
	endtask

	// number of bad beats inside the run
	function automatic int mask_count(input logic [63:0] mask, input int n_beats);
		int c;
		int i;
		c = 0;
		for (i = 0; i < n_beats; i++) begin
			c += mask[i];
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////////////////////

	always @(posedge pcie_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("checks: %0d errors: %0d", check_cnt, error_count);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed          = 8;
		error_count   = 0;
		check_cnt     = 0;
		cycle_cnt     = 0;
		exp_err_cnt   = '0;
		exp_th        = '0;
		exp_lat       = '0;
		exp_idx       = '0;
		rd_start      = 1'b0;
		rd_addr       = '0;
		rd_length     = '0;
		rd_offset     = '0;
		cmd_ready     = 1'b0;
		rd_data_valid = 1'b0;
		rd_data       = '0;

		// idle after reset, all results zero
		@(posedge pcie_aresetn);
		@(negedge pcie_clk);
		check_val("cmd_valid", 0, cmd_valid);
		check_val("rd_th_sum", 0, rd_th_sum);
		check_val("rd_lat_sum", 0, rd_lat_sum);
		check_val("error_cnt", 0, error_cnt);
		check_val("error_index", 0, error_index);

		// clean run with a stalled core and random idles
		run_transfer(64'h0000_0001_2345_6000, 8, 3, idle_max, 4, 32'h100, 64'h0);
		// a held start level gives no second command
		repeat (5) begin
			@(negedge pcie_clk);
			check_val("cmd_valid", 0, cmd_valid);
		end
		rd_start = 1'b0;
		repeat (3) @(negedge pcie_clk);

		// run with some corrupted beats
		// bad beats never at index 0
		// so error_index always moves off its cleared value
		gap_b    = {$random(seed)} % 5;
		bad_mask = '0;
		for (k = 0; k < 3; k++) begin
			bad_mask[1 + {$random(seed)} % 15] = 1'b1;
		end
		run_transfer(64'h0000_00ab_cd00_0040, 16, gap_b, idle_max, 1, 32'h5000, bad_mask);
		rd_start = 1'b0;
		repeat (3) @(negedge pcie_clk);

		// stray beats while idle leave every result alone
		repeat (3) begin
			rd_data       = make_beat(0, 32'h0, 1'b1);
			rd_data_valid = 1'b1;
			@(negedge pcie_clk);
		end
		rd_data_valid = 1'b0;
		check_val("rd_th_sum", exp_th, rd_th_sum);
		check_val("rd_lat_sum", exp_lat, rd_lat_sum);
		check_val("error_cnt", exp_err_cnt, error_cnt);
		check_val("error_index", exp_idx, error_index);

		// back to back beats, offset wraps past the top
		run_transfer(64'h0000_0000_0000_1000, 4, 0, 0, 0, 32'hffff_fffe, 64'h0);
		rd_start = 1'b0;
		repeat (2) @(negedge pcie_clk);

		$display("checks: %0d errors: %0d", check_cnt, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic pcie_clk,
	output logic pcie_aresetn
);

	// 50 MHz, 20 ns period
	initial begin
		pcie_clk = 1'b0;
		forever begin
			#10 pcie_clk = ~pcie_clk;
		end
	end

	// reset low over three rising edges, released on a falling edge
	initial begin
		pcie_aresetn = 1'b0;
		repeat (3) @(posedge pcie_clk);
		@(negedge pcie_clk);
		pcie_aresetn = 1'b1;
	end

endmodule

`default_nettype wire

/* dma_rd_bench.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_rd_bench import dma_bench_pkg::*; (
	input  wire               pcie_clk,
	input  wire               pcie_aresetn,
	// run control
	input  wire               rd_start,
	input  wire  [addr_w-1:0] rd_addr,
	input  wire  [len_w-1:0]  rd_length,
	input  wire  [cnt_w-1:0]  rd_offset,
	// read command to the dma core
	output logic              cmd_valid,
	input  wire               cmd_ready,
	output logic [addr_w-1:0] cmd_addr,
	output logic [len_w-1:0]  cmd_length,
	// returned read data
	input  wire               rd_data_valid,
	input  wire  [data_w-1:0] rd_data,
	// results
	output logic [cnt_w-1:0]  rd_th_sum,
	output logic [cnt_w-1:0]  rd_lat_sum,
	output logic [cnt_w-1:0]  error_cnt,
	output logic [cnt_w-1:0]  error_index
);

	logic start_pulse;
	logic cmd_fire;
	logic in_data;
	logic beat_last;

	// command payload straight from the run inputs
	assign cmd_addr   = rd_addr;
	assign cmd_length = rd_length;

	dma_rd_fsm u_fsm (
		.pcie_clk     (pcie_clk),
		.pcie_aresetn (pcie_aresetn),
		.rd_start     (rd_start),
		.cmd_ready    (cmd_ready),
		.beat_last    (beat_last),
		.cmd_valid    (cmd_valid),
		.start_pulse  (start_pulse),
		.cmd_fire     (cmd_fire),
		.in_data      (in_data)
	);

	dma_perf_timer u_timer (
		.pcie_clk      (pcie_clk),
		.pcie_aresetn  (pcie_aresetn),
		.start_pulse   (start_pulse),
		.cmd_fire      (cmd_fire),
		.in_data       (in_data),
		.rd_data_valid (rd_data_valid),
		.rd_th_sum     (rd_th_sum),
		.rd_lat_sum    (rd_lat_sum)
	);

	dma_rd_checker u_checker (
		.pcie_clk      (pcie_clk),
		.pcie_aresetn  (pcie_aresetn),
		.start_pulse   (start_pulse),
		.in_data       (in_data),
		.rd_length     (rd_length),
		.rd_offset     (rd_offset),
		.rd_data_valid (rd_data_valid),
		.rd_data       (rd_data),
		.beat_last     (beat_last),
		.error_cnt     (error_cnt),
		.error_index   (error_index)
	);

endmodule

`default_nettype wire

/* dma_rd_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_rd_checker import dma_bench_pkg::*; (
	input  wire               pcie_clk,
	input  wire               pcie_aresetn,
	input  wire               start_pulse,
	input  wire               in_data,
	input  wire  [len_w-1:0]  rd_length,
	input  wire  [cnt_w-1:0]  rd_offset,
	input  wire               rd_data_valid,
	input  wire  [data_w-1:0] rd_data,
	output logic              beat_last,
	output logic [cnt_w-1:0]  error_cnt,
	output logic [cnt_w-1:0]  error_index
);

	logic [len_w-1:0] beat_total;
	logic [cnt_w-1:0] last_idx;
	logic [cnt_w-1:0] offset;
	logic [cnt_w-1:0] beat_idx;
	logic             beat_hit;
	logic             beat_bad;
	logic             err_seen;

	////////////////////////////////////////////////////////////////////////////
	// run setup
	////////////////////////////////////////////////////////////////////////////

	// bytes to beats
	assign beat_total = rd_length >> beat_bytes_log2;

	// snapshot at start, inputs are meant to stay put anyway
	always_ff @(posedge pcie_clk) begin
		if (start_pulse) begin
			last_idx <= cnt_w'(beat_total - 1'b1);
			offset   <= rd_offset;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// beat counting
	////////////////////////////////////////////////////////////////////////////

	// data sink is always ready, valid alone is a beat
	// stray beats outside the data phase are dropped here
	assign beat_hit  = in_data & rd_data_valid;
	assign beat_last = beat_hit & (beat_idx == last_idx);

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			beat_idx <= '0;
		end else if (start_pulse || beat_last) begin
			beat_idx <= '0;
		end else if (beat_hit) begin
			beat_idx <= beat_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pattern check
	////////////////////////////////////////////////////////////////////////////

	// expected low word is index plus offset
	assign beat_bad = beat_hit & (rd_data[cnt_w-1:0] != (beat_idx + offset));

	// running total across runs, reset only
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			error_cnt <= '0;
		end else if (beat_bad) begin
			error_cnt <= error_cnt + 1'b1;
		end
	end

	// first bad beat of the run wins
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			err_seen    <= 1'b0;
			error_index <= '0;
		end else if (start_pulse) begin
			err_seen    <= 1'b0;
			error_index <= '0;
		end else if (beat_bad && !err_seen) begin
			err_seen    <= 1'b1;
			error_index <= beat_idx;
		end
	end

endmodule

`default_nettype wire

/* dma_perf_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_perf_timer import dma_bench_pkg::*; (
	input  wire              pcie_clk,
	input  wire              pcie_aresetn,
	input  wire              start_pulse,
	input  wire              cmd_fire,
	input  wire              in_data,
	input  wire              rd_data_valid,
	output logic [cnt_w-1:0] rd_th_sum,
	output logic [cnt_w-1:0] rd_lat_sum
);

	////////////////////////////////////////////////////////////////////////////
	// throughput counter
	////////////////////////////////////////////////////////////////////////////

	// counts every cycle of the data phase, gaps included
	// last count lands on the edge of the final beat
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			rd_th_sum <= '0;
		end else if (start_pulse) begin
			rd_th_sum <= '0;
		end else if (in_data) begin
			rd_th_sum <= rd_th_sum + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// latency counter
	////////////////////////////////////////////////////////////////////////////

	logic lat_en;
	logic first_beat;

	// window opens on entry to the data phase
	// and closes before the phase can end
	assign first_beat = lat_en & rd_data_valid;

	// open at command fire, close on the first beat
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			lat_en <= 1'b0;
		end else if (first_beat) begin
			lat_en <= 1'b0;
		end else if (cmd_fire) begin
			lat_en <= 1'b1;
		end
	end

	// first beat right after fire gives a sum of 1
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			rd_lat_sum <= '0;
		end else if (start_pulse) begin
			rd_lat_sum <= '0;
		end else if (lat_en) begin
			rd_lat_sum <= rd_lat_sum + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* dma_rd_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_rd_fsm import dma_bench_pkg::*; (
	input  wire  pcie_clk,
	input  wire  pcie_aresetn,
	input  wire  rd_start,
	input  wire  cmd_ready,
	input  wire  beat_last,
	output logic cmd_valid,
	output logic start_pulse,
	output logic cmd_fire,
	output logic in_data
);

	////////////////////////////////////////////////////////////////////////////
	// start synchronizer and edge detect
	////////////////////////////////////////////////////////////////////////////

	logic      rd_start_r;
	logic      rd_start_rr;
	rd_state_t state;

	// two stage capture of the start level
	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			rd_start_r  <= 1'b0;
			rd_start_rr <= 1'b0;
		end else begin
			rd_start_r  <= rd_start;
			rd_start_rr <= rd_start_r;
		end
	end

	// rising edge only, a held level gives one pulse
	// a start while a run is busy is dropped
	assign start_pulse = rd_start_r & ~rd_start_rr & (state == st_idle);

	////////////////////////////////////////////////////////////////////////////
	// read command FSM
	////////////////////////////////////////////////////////////////////////////

	// valid is a pure decode of the state
	assign cmd_valid = (state == st_cmd);

	// handshake edge, one cycle, shared with the timer
	assign cmd_fire = cmd_valid & cmd_ready;

	// data phase level for timer and checker
	assign in_data = (state == st_data);

	always_ff @(posedge pcie_clk) begin
		if (!pcie_aresetn) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (start_pulse) begin
						state <= st_cmd;
					end
				end
				st_cmd: begin
					// hold until the core takes the command
					if (cmd_fire) begin
						state <= st_data;
					end
				end
				st_data: begin
					// checker flags the final beat
					if (beat_last) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* dma_bench_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared widths and types for the dma read benchmark
////////////////////////////////////////////////////////////////////////////

package dma_bench_pkg;

	// host address width on the read command
	localparam int addr_w = 64;

	// byte length carried by the read command
	localparam int len_w = 32;

	// counters, status words, offset and pattern word
	localparam int cnt_w = 32;

	// one dma data beat
	localparam int data_w = 512;

	// 64 bytes per beat
	// beat count = length >> beat_bytes_log2
	localparam int beat_bytes_log2 = 6;

	// read command machine
	//   st_idle  waiting for a start edge
	//   st_cmd   command valid, waiting for ready
	//   st_data  collecting beats until the last one
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_cmd  = 2'd1,
		st_data = 2'd2
	} rd_state_t;

endpackage

`default_nettype wire
